/* verilog/apuPkg.sv */
`default_nettype none

package apuPkg;

	// ************************************************************
	// address map.
	// ************************************************************

	localparam logic [15:0] apuWindowBase = 16'h4000;	// 0x4000..0x401F.
	localparam logic [15:0] oamDataAddr = 16'h2004;	// sprite data port.
	localparam int chanRegCount = 20;	// 0x4000..0x4013.

	// register offsets within the window, low 5 address bits.
	typedef enum logic [4:0] {
		selPulse1Ctrl  = 5'h00,
		selPulse1Sweep = 5'h01,
		selPulse1Lo    = 5'h02,
		selPulse1Hi    = 5'h03,
		selPulse2Ctrl  = 5'h04,
		selPulse2Sweep = 5'h05,
		selPulse2Lo    = 5'h06,
		selPulse2Hi    = 5'h07,
		selTriCtrl     = 5'h08,
		selTriUnused   = 5'h09,
		selTriLo       = 5'h0A,
		selTriHi       = 5'h0B,
		selNoiseCtrl   = 5'h0C,
		selNoiseUnused = 5'h0D,
		selNoiseLo     = 5'h0E,
		selNoiseHi     = 5'h0F,
		selDmcCtrl     = 5'h10,
		selDmcLoad     = 5'h11,
		selDmcAddr     = 5'h12,
		selDmcLength   = 5'h13,
		selSpriteDma   = 5'h14,
		selStatus      = 5'h15,
		selJoy1        = 5'h16,
		selJoy2        = 5'h17,
		selDbgA        = 5'h18,	// debug only.
		selDbgB        = 5'h19,	// debug only.
		selDbgC        = 5'h1A	// debug only.
	} regSel;

	typedef enum logic [1:0] {
		dmaIdle  = 2'd0,
		dmaRead  = 2'd1,
		dmaWrite = 2'd2
	} dmaState;

endpackage

`default_nettype wire

/* verilog/apuRegDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module apuRegDecode (
	input logic busValid,
	input logic busRnW,
	input logic [15:0] busAddr,
	input logic dbg,
	output apuPkg::regSel regSel,
	output logic regWr,
	output logic regRd,
	output logic rdHit
);

	logic inWindow;
	logic wrCycle;
	logic rdCycle;
	logic chanHit;

	// ************************************************************
	// window check on the upper address bits.
	// ************************************************************

	assign inWindow = busValid && (busAddr[15:5] == apuPkg::apuWindowBase[15:5]);
	assign wrCycle = inWindow && !busRnW;
	assign rdCycle = inWindow && busRnW;

	// the low 5 bits pick the register, like the PLA inputs.
	assign regSel = apuPkg::regSel'(busAddr[4:0]);
	assign chanHit = busAddr[4:0] < 5'(apuPkg::chanRegCount);

	// ************************************************************
	// strobe generation.
	// ************************************************************

	always_comb begin
		regWr = 1'b0;
		regRd = 1'b0;
		rdHit = 1'b0;
		case (regSel)
			apuPkg::selSpriteDma: begin
				regWr = wrCycle;	// starts the sprite DMA.
			end
			apuPkg::selStatus: begin
				regWr = wrCycle;
				regRd = rdCycle;
				rdHit = rdCycle;	// enable bits come from the register file.
			end
			apuPkg::selJoy1,
			apuPkg::selJoy2: begin
				// controller data itself comes from the bus.
				regWr = wrCycle;
				regRd = rdCycle;
			end
			apuPkg::selDbgA,
			apuPkg::selDbgB: begin
				regRd = rdCycle && dbg;	// read only, debug pin required.
				rdHit = rdCycle && dbg;
			end
			apuPkg::selDbgC: begin
				regWr = wrCycle && dbg;
				regRd = rdCycle && dbg;
				rdHit = rdCycle && dbg;
			end
			default: begin
				// channel registers are write only.
				regWr = wrCycle && chanHit;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/busArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module busArbiter (
	input logic phi0,
	input logic cpuValid,
	input logic cpuRnW,
	input logic [15:0] cpuAddr,
	input logic [7:0] cpuWrData,
	output logic cpuRdy,
	output logic [7:0] cpuRdData,
	input logic dmaReq,
	input logic dmaRnW,
	input logic [15:0] dmaAddr,
	input logic [7:0] dmaWrData,
	output logic [7:0] dmaRdData,
	input logic [7:0] apuRdData,
	input logic rdHit,
	input logic [7:0] busRdData,
	output logic busValid,
	output logic busRnW,
	output logic [15:0] busAddr,
	output logic [7:0] busWrData
);

	logic [7:0] rdData;
	logic [7:0] wrData;
	logic [7:0] dataHold;	// last value seen on the data lines.

	// the DMA always wins, the CPU stalls while it owns the bus.
	assign cpuRdy = !dmaReq;

	assign busValid = dmaReq || cpuValid;
	assign busRnW = dmaReq ? dmaRnW : cpuRnW;
	assign busAddr = dmaReq ? dmaAddr : cpuAddr;
	assign wrData = dmaReq ? dmaWrData : cpuWrData;

	// nobody drives the data lines on a read, so they keep their charge.
	assign busWrData = busRnW ? dataHold : wrData;

	assign rdData = rdHit ? apuRdData : busRdData;	// APU registers or memory.
	assign cpuRdData = rdData;
	assign dmaRdData = rdData;

	always_ff @(posedge phi0) begin
		if (busValid) begin
			dataHold <= busRnW ? rdData : wrData;
		end
	end

endmodule

`default_nettype wire

/* verilog/spriteDma.sv */
`timescale 1ns/1ns
`default_nettype none

module spriteDma (
	input logic phi0,
	input logic rstN,
	input logic dmaStart,
	input logic [7:0] dmaPage,
	output logic dmaReq,
	output logic dmaRnW,
	output logic [15:0] dmaAddr,
	output logic [7:0] dmaWrData,
	input logic [7:0] dmaRdData
);

	apuPkg::dmaState state;
	logic [7:0] byteCnt;	// index within the page.
	logic [7:0] dataLatch;	// byte carried from read to write.

	// ************************************************************
	// state machine, one read then one write per byte.
	// ************************************************************

	always_ff @(posedge phi0) begin
		if (!rstN) begin
			state <= apuPkg::dmaIdle;
			byteCnt <= 8'd0;
		end else begin
			case (state)
				apuPkg::dmaIdle: begin
					if (dmaStart) begin
						state <= apuPkg::dmaRead;
						byteCnt <= 8'd0;
					end
				end
				apuPkg::dmaRead: begin
					state <= apuPkg::dmaWrite;
				end
				apuPkg::dmaWrite: begin
					byteCnt <= byteCnt + 8'd1;
					if (byteCnt == 8'hFF) begin
						state <= apuPkg::dmaIdle;	// whole page moved.
					end else begin
						state <= apuPkg::dmaRead;
					end
				end
				default: begin
					state <= apuPkg::dmaIdle;
				end
			endcase
		end
	end

	// the page register stays stable while the CPU is stalled.
	always_ff @(posedge phi0) begin
		if (state == apuPkg::dmaRead) begin
			dataLatch <= dmaRdData;
		end
	end

	// ************************************************************
	// bus request.
	// ************************************************************

	assign dmaReq = (state != apuPkg::dmaIdle);
	assign dmaRnW = (state != apuPkg::dmaWrite);
	assign dmaAddr = (state == apuPkg::dmaWrite) ? apuPkg::oamDataAddr : {dmaPage, byteCnt};
	assign dmaWrData = dataLatch;

endmodule

`default_nettype wire

/* verilog/apuRegFile.sv */
`timescale 1ns/1ns
`default_nettype none

module apuRegFile (
	input logic phi0,
	input logic rstN,
	input apuPkg::regSel regSel,
	input logic regWr,
	input logic regRd,
	input logic [7:0] busWrData,
	output logic [apuPkg::chanRegCount*8-1:0] chanRegs,
	output logic [4:0] statusEn,
	output logic joyStrobe,
	output logic joyRd1,
	output logic joyRd2,
	output logic dmaStart,
	output logic [7:0] dmaPage,
	output logic [7:0] apuRdData
);

	logic [7:0] dbgLatch;
	logic chanWr;

	assign chanWr = regWr && (regSel < 5'(apuPkg::chanRegCount));

	// ************************************************************
	// register writes.
	// ************************************************************

	always_ff @(posedge phi0) begin
		if (!rstN) begin
			chanRegs <= '0;
			statusEn <= 5'd0;
			joyStrobe <= 1'b0;
			dmaPage <= 8'd0;
			dbgLatch <= 8'd0;
		end else if (regWr) begin
			if (chanWr) begin
				chanRegs[{regSel, 3'b000} +: 8] <= busWrData;	// byte k is offset k.
			end
			case (regSel)
				apuPkg::selSpriteDma: dmaPage <= busWrData;
				apuPkg::selStatus: statusEn <= busWrData[4:0];
				apuPkg::selJoy1: joyStrobe <= busWrData[0];
				apuPkg::selDbgC: dbgLatch <= busWrData;
				default: ;	// 0x17 frame counter is not modelled.
			endcase
		end
	end

	assign dmaStart = regWr && (regSel == apuPkg::selSpriteDma);

	// controller port read pulses.
	assign joyRd1 = regRd && (regSel == apuPkg::selJoy1);
	assign joyRd2 = regRd && (regSel == apuPkg::selJoy2);

	// ************************************************************
	// read data.
	// ************************************************************

	always_comb begin
		apuRdData = 8'h00;
		if (regRd) begin
			case (regSel)
				apuPkg::selStatus: apuRdData = {3'b000, statusEn};
				apuPkg::selDbgA: apuRdData = {joyStrobe, 2'b00, statusEn};
				apuPkg::selDbgB: apuRdData = dmaPage;	// last DMA page.
				apuPkg::selDbgC: apuRdData = dbgLatch;
				default: apuRdData = 8'h00;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/apuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module apuTop (
	input logic phi0,
	input logic rstN,
	input logic cpuValid,
	input logic cpuRnW,
	input logic [15:0] cpuAddr,
	input logic [7:0] cpuWrData,
	output logic cpuRdy,
	output logic [7:0] cpuRdData,
	output logic busValid,
	output logic busRnW,
	output logic [15:0] busAddr,
	output logic [7:0] busWrData,
	input logic [7:0] busRdData,
	input logic dbg,
	output logic [apuPkg::chanRegCount*8-1:0] chanRegs,
	output logic [4:0] statusEn,
	output logic joyStrobe,
	output logic joyRd1,
	output logic joyRd2
);

	// DMA master.
	logic dmaReq;
	logic dmaRnW;
	logic [15:0] dmaAddr;
	logic [7:0] dmaWrData;
	logic [7:0] dmaRdData;
	logic dmaStart;
	logic [7:0] dmaPage;

	// register decode.
	apuPkg::regSel regSel;
	logic regWr;
	logic regRd;
	logic rdHit;
	logic [7:0] apuRdData;

	busArbiter u_busArbiter (
		.phi0(phi0),
		.cpuValid(cpuValid),
		.cpuRnW(cpuRnW),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuRdy(cpuRdy),
		.cpuRdData(cpuRdData),
		.dmaReq(dmaReq),
		.dmaRnW(dmaRnW),
		.dmaAddr(dmaAddr),
		.dmaWrData(dmaWrData),
		.dmaRdData(dmaRdData),
		.apuRdData(apuRdData),
		.rdHit(rdHit),
		.busRdData(busRdData),
		.busValid(busValid),
		.busRnW(busRnW),
		.busAddr(busAddr),
		.busWrData(busWrData)
	);

	spriteDma u_spriteDma (
		.phi0(phi0),
		.rstN(rstN),
		.dmaStart(dmaStart),
		.dmaPage(dmaPage),
		.dmaReq(dmaReq),
		.dmaRnW(dmaRnW),
		.dmaAddr(dmaAddr),
		.dmaWrData(dmaWrData),
		.dmaRdData(dmaRdData)
	);

	apuRegDecode u_apuRegDecode (
		.busValid(busValid),
		.busRnW(busRnW),
		.busAddr(busAddr),
		.dbg(dbg),
		.regSel(regSel),
		.regWr(regWr),
		.regRd(regRd),
		.rdHit(rdHit)
	);

	apuRegFile u_apuRegFile (
		.phi0(phi0),
		.rstN(rstN),
		.regSel(regSel),
		.regWr(regWr),
		.regRd(regRd),
		.busWrData(busWrData),
		.chanRegs(chanRegs),
		.statusEn(statusEn),
		.joyStrobe(joyStrobe),
		.joyRd1(joyRd1),
		.joyRd2(joyRd2),
		.dmaStart(dmaStart),
		.dmaPage(dmaPage),
		.apuRdData(apuRdData)
	);

endmodule

`default_nettype wire

/* tb/apuTb.sv */
`timescale 1ns/1ns
`default_nettype none

module apuTb;

	logic phi0;
	logic rstN;
	logic cpuValid;
	logic cpuRnW;
	logic [15:0] cpuAddr;
	logic [7:0] cpuWrData;
	logic cpuRdy;
	logic [7:0] cpuRdData;
	logic busValid;
	logic busRnW;
	logic [15:0] busAddr;
	logic [7:0] busWrData;
	logic [7:0] busRdData;
	logic dbg;
	logic [159:0] chanRegs;
	logic [4:0] statusEn;
	logic joyStrobe;
	logic joyRd1;
	logic joyRd2;

	// stimulus table with one row per CPU access.
	logic tRnW [64];
	logic [15:0] tAddr [64];
	logic [7:0] tData [64];
	logic tDbg [64];
	logic [7:0] tExp [64];
	int rowCount = 0;
	int dmaRows = 0;

	logic [159:0] chanShadow = '0;
	logic [4:0] statusShadow = 5'd0;
	logic joyShadow = 1'b0;
	logic [7:0] dmaPageExp = 8'd0;
	logic [7:0] dmaIdx = 8'd0;
	int dmaCycles = 0;
	int dmaWrites = 0;
	int dmaRuns = 0;
	int cycleCount = 0;
	int timeoutLimit = 0;
	int seed;

	apuTop i_apuTop (.*);

	// memory answers with the low address byte xor the high one.
	function automatic logic [7:0] memValue(input logic [15:0] a);
		return a[7:0] ^ a[15:8];
	endfunction

	assign busRdData = memValue(busAddr);

	initial begin
		phi0 = 1'b0;
		forever #2 phi0 = ~phi0;
	end

	task automatic checkEq(input logic [159:0] actual, input logic [159:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
			$display("Errors found");
			$fatal(1, "a checked value did not match");
		end
	endtask

	task automatic addRow(input logic rnW, input logic [15:0] addr, input logic [7:0] data,
			input logic dbgPin, input logic [7:0] expData);
		tRnW[rowCount] = rnW;
		tAddr[rowCount] = addr;
		tData[rowCount] = data;
		tDbg[rowCount] = dbgPin;
		tExp[rowCount] = expData;
		if (!rnW && addr == 16'h4014) dmaRows++;	// sprite DMA row.
		rowCount++;
	endtask

	// ************************************************************
	// one access held until the arbiter lets the CPU through.
	// ************************************************************

	task automatic applyRow(input int r);
		int k;
		@(negedge phi0);
		cpuValid = 1'b1;
		cpuRnW = tRnW[r];
		cpuAddr = tAddr[r];
		cpuWrData = tData[r];
		dbg = tDbg[r];
		if (!tRnW[r] && tAddr[r] == 16'h4014) dmaPageExp = tData[r];
		#1;
		while (!cpuRdy) begin
			@(negedge phi0);
			#1;
		end
		if (tRnW[r]) checkEq(160'(cpuRdData), 160'(tExp[r]), "read data");
		checkEq(160'(joyRd1), 160'(tRnW[r] && tAddr[r] == 16'h4016), "joyRd1 pulse");
		checkEq(160'(joyRd2), 160'(tRnW[r] && tAddr[r] == 16'h4017), "joyRd2 pulse");
		@(negedge phi0);
		cpuValid = 1'b0;
		#1;
		if (!tRnW[r]) begin
			k = int'(tAddr[r][4:0]);
			if (tAddr[r] >= 16'h4000 && tAddr[r] <= 16'h4013) chanShadow[k*8 +: 8] = tData[r];
			if (tAddr[r] == 16'h4015) statusShadow = tData[r][4:0];
			if (tAddr[r] == 16'h4016) joyShadow = tData[r][0];
			if (tAddr[r] == 16'h4014) checkEq(160'(cpuRdy), 160'd0, "cpuRdy after DMA start");
		end
		checkEq(chanRegs, chanShadow, "channel registers");
		checkEq(160'(statusEn), 160'(statusShadow), "status enables");
		checkEq(160'(joyStrobe), 160'(joyShadow), "joy strobe");
		checkEq(160'({joyRd1, joyRd2}), 160'd0, "joy read pulse length");
	endtask

	// ************************************************************
	// DMA monitor with one step per stalled cycle.
	// ************************************************************

	always begin
		@(negedge phi0);
		#1;
		if (rstN && !cpuRdy) begin
			checkEq(160'(busValid), 160'd1, "DMA bus valid");
			checkEq(160'(busRnW), 160'(dmaCycles % 2 == 0), "DMA read and write order");
			if (dmaCycles % 2 == 0) begin
				checkEq(160'(busAddr), 160'({dmaPageExp, dmaIdx}), "DMA read address");
			end else begin
				checkEq(160'(busAddr), 160'(16'h2004), "DMA write address");
				checkEq(160'(busWrData), 160'(dmaIdx ^ dmaPageExp), "DMA write data");
				dmaIdx = dmaIdx + 8'd1;
				dmaWrites++;
			end
			dmaCycles++;
		end else if (dmaCycles != 0) begin
			checkEq(160'(dmaCycles), 160'd512, "DMA stall length");
			checkEq(160'(dmaWrites), 160'd256, "DMA write count");
			dmaCycles = 0;
			dmaWrites = 0;
			dmaIdx = 8'd0;
			dmaRuns++;
		end
	end

	always @(posedge phi0) begin
		cycleCount++;
		if (timeoutLimit != 0 && cycleCount >= timeoutLimit) begin
			$display("Errors found");
			$fatal(1, "timeout, the run did not finish in time");
		end
	end

	initial begin
		int rnd;
		logic [7:0] dbgVal;
		cpuValid = 1'b0;
		cpuRnW = 1'b1;
		cpuAddr = 16'h0000;
		cpuWrData = 8'h00;
		dbg = 1'b0;
		rstN = 1'b0;
		seed = 36413;

		// channel writes with random data, then open bus reads.
		rnd = $random(seed);
		addRow(1'b0, 16'h4000, rnd[7:0], 1'b0, 8'h00);
		rnd = $random(seed);
		addRow(1'b0, 16'h4007, rnd[7:0], 1'b0, 8'h00);
		rnd = $random(seed);
		addRow(1'b0, 16'h4013, rnd[7:0], 1'b0, 8'h00);
		addRow(1'b1, 16'h4003, 8'h00, 1'b0, memValue(16'h4003));
		addRow(1'b1, 16'h1234, 8'h00, 1'b0, memValue(16'h1234));
		addRow(1'b0, 16'h4015, 8'hFF, 1'b0, 8'h00);
		addRow(1'b1, 16'h4015, 8'h00, 1'b0, 8'h1F);	// upper bits read as zero.
		addRow(1'b0, 16'h4016, 8'h01, 1'b0, 8'h00);
		addRow(1'b1, 16'h4016, 8'h00, 1'b0, memValue(16'h4016));
		addRow(1'b1, 16'h4017, 8'h00, 1'b0, memValue(16'h4017));
		// debug registers.
		rnd = $random(seed);
		dbgVal = rnd[7:0];
		addRow(1'b0, 16'h401A, dbgVal, 1'b1, 8'h00);
		addRow(1'b1, 16'h401A, 8'h00, 1'b1, dbgVal);
		addRow(1'b0, 16'h401A, ~dbgVal, 1'b0, 8'h00);	// ignored without dbg.
		addRow(1'b1, 16'h401A, 8'h00, 1'b0, memValue(16'h401A));
		addRow(1'b1, 16'h401A, 8'h00, 1'b1, dbgVal);
		addRow(1'b1, 16'h4018, 8'h00, 1'b1, 8'h9F);
		// sprite DMA with the next row issued while the CPU is stalled.
		addRow(1'b0, 16'h4014, 8'h03, 1'b0, 8'h00);
		addRow(1'b1, 16'h4015, 8'h00, 1'b0, 8'h1F);
		addRow(1'b1, 16'h4019, 8'h00, 1'b1, 8'h03);
		addRow(1'b1, 16'h4019, 8'h00, 1'b0, memValue(16'h4019));
		addRow(1'b0, 16'h4015, 8'h0A, 1'b0, 8'h00);
		addRow(1'b0, 16'h4016, 8'h00, 1'b0, 8'h00);
		addRow(1'b1, 16'h4018, 8'h00, 1'b1, 8'h0A);
		addRow(1'b0, 16'h4014, 8'hC7, 1'b0, 8'h00);
		addRow(1'b1, 16'h0345, 8'h00, 1'b0, memValue(16'h0345));
		addRow(1'b1, 16'h4019, 8'h00, 1'b1, 8'hC7);
		timeoutLimit = (rowCount + 520 * dmaRows) * 2;

		repeat (10) @(negedge phi0);
		rstN = 1'b1;
		#1;
		checkEq(chanRegs, 160'd0, "channel registers after reset");
		checkEq(160'({statusEn, joyStrobe}), 160'd0, "status after reset");
		checkEq(160'({cpuRdy, busValid, joyRd1, joyRd2}), 160'b1000, "bus state after reset");

		for (int r = 0; r < rowCount; r++) begin
			applyRow(r);
		end

		repeat (2) @(negedge phi0);
		#1;
		checkEq(160'(busValid), 160'd0, "bus idle at end");
		if (dmaRuns == dmaRows) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "the number of completed sprite DMA runs is wrong");
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
verilog/apuPkg.sv
verilog/apuRegDecode.sv
verilog/busArbiter.sv
verilog/spriteDma.sv
verilog/apuRegFile.sv
verilog/apuTop.sv
tb/apuTb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it; the exit status is the result.
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module apuTb -f filelist.f -o apuSim &&
./obj_dir/apuSim || exit 1
